// ==== bus_tx_hub.f ====
logic/bus_tx_pkg.sv
logic/tx_request_stage.sv
logic/frame_fifo.sv
logic/bit_serializer.sv
logic/bus_demux.sv
logic/bus_tx_hub.sv
tb/bus_tx_hub_checker.sv
tb/bus_tx_hub_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module bus_tx_hub_tb \
  -f bus_tx_hub.f -o bus_tx_hub_sim > build.log 2>&1 \
  || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/bus_tx_hub_sim > sim.log 2>&1

grep -qx "Result: PASSED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// ==== tb/bus_tx_hub_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_tx_hub_tb
  import bus_tx_pkg::*;
;

  // same values as the DUT defaults
  localparam int         fifo_depth   = 8;
  localparam int         bit_div      = 4;
  localparam logic       idle_level   = 1'b1;
  localparam bus_lines_t idle_lines   = {num_buses{idle_level}};
  // 18 bits per frame plus the pop cycle in front of the next one
  localparam int         frame_cycles = (payload_w + 2) * bit_div + 1;
  localparam int         gap_cycles   = frame_cycles + 8;
  localparam int         burst_len    = 12;

  typedef struct packed {
    bus_mask_t    mask;
    tx_frame_t    frame;
    logic [15:0]  idle;
    logic         accept;
  } stim_row_t;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        wr_en;
  tx_frame_t   wr_frame;
  bus_mask_t   bus_enable;
  bus_lines_t  tx_lines;
  logic        tx_busy;
  logic [15:0] drop_count;

  stim_row_t   stim_table[$];
  tx_frame_t   exp_q[$];
  tx_frame_t   rx_q[$];
  integer      seed;
  int          watchdog_cycles;
  bit          table_ready = 1'b0;

  always #2 clk = ~clk;

  bus_tx_hub DUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .wr_en      (wr_en),
    .wr_frame   (wr_frame),
    .bus_enable (bus_enable),
    .tx_lines   (tx_lines),
    .tx_busy    (tx_busy),
    .drop_count (drop_count)
  );

  bind bus_tx_hub bus_tx_hub_checker #(.IDLE_LEVEL(IDLE_LEVEL)) u_checker (
    .clk      (clk),
    .arst_n   (arst_n),
    .tx_lines (tx_lines),
    .tx_busy  (tx_busy),
    .push     (push),
    .full     (full)
  );

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_frame(string name, tx_frame_t actual, tx_frame_t expected);
    if (actual !== expected)
    begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("Result: FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic compare_lines(string name, bus_lines_t actual, bus_lines_t expected);
    if (actual !== expected)
    begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("Result: FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic compare_count(string name, logic [15:0] actual, logic [15:0] expected);
    if (actual !== expected)
    begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("Result: FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic compare_flag(string name, logic actual, logic expected);
    if (actual !== expected)
    begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("Result: FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_row(bus_mask_t mask, tx_frame_t frame, int idle, logic accept);
    stim_row_t row;
    row.mask   = mask;
    row.frame  = frame;
    row.idle   = 16'(idle);
    row.accept = accept;
    stim_table.push_back(row);
  endtask

  task automatic build_table();
    tx_frame_t f;
    integer    r;
    for (int b = 0; b < num_buses; b++)
    begin
      f.bus  = bus_id_t'(b);
      f.data = 16'h3ca5 ^ 16'(b * 4369);
      add_row('1, f, gap_cycles, 1'b1);
    end
    // only bit 7 of the mask matters for this one
    f = '{bus: 5'd7, data: 16'h8001};
    add_row(16'h00ff, f, gap_cycles, 1'b1);
    for (int b = num_buses; b < 32; b++)
    begin
      f.bus  = bus_id_t'(b);
      f.data = 16'hff00 ^ 16'(b);
      add_row('1, f, 2, 1'b0);
    end
    f = '{bus: 5'd3, data: 16'h0f0f};
    add_row(16'hfff7, f, 2, 1'b0);
    f = '{bus: 5'd12, data: 16'hf0f0};
    add_row(16'h0fff, f, 2, 1'b0);
    // the burst starts on an idle hub, so the serializer takes the first frame at once
    // and stays busy past the last strobe; the FIFO then holds depth more
    for (int k = 0; k < burst_len; k++)
    begin
      r      = $random(seed);
      f.bus  = bus_id_t'(r[3:0]);
      f.data = r[31:16];
      add_row('1, f, (k == 0) ? gap_cycles : 0, k < (fifo_depth + 1));
    end
    f = '{bus: 5'd9, data: 16'h0000};
    add_row('1, f, gap_cycles, 1'b1);
    f = '{bus: 5'd14, data: 16'hffff};
    add_row('1, f, gap_cycles, 1'b1);
  endtask

  function automatic int find_active(bus_lines_t lines);
    int idx;
    idx = -1;
    for (int i = num_buses - 1; i >= 0; i--)
      if (lines[i] != idle_level)
        idx = i;
    return idx;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // line monitor
  ////////////////////////////////////////////////////////////////////////////

  // the start bit is seen half a clock in, samples then land mid-bit
  initial
  begin : line_monitor
    int         line;
    bus_lines_t exp_lines;
    tx_frame_t  rx;
    forever
    begin
      @(negedge clk);
      if (arst_n && (tx_lines != idle_lines))
      begin
        line            = find_active(tx_lines);
        rx.bus          = bus_id_t'(line);
        exp_lines       = idle_lines;
        exp_lines[line] = ~idle_level;
        repeat (bit_div / 2) @(negedge clk);
        compare_lines("tx_lines", tx_lines, exp_lines);
        for (int k = 0; k < payload_w; k++)
        begin
          repeat (bit_div) @(negedge clk);
          rx.data[k]      = tx_lines[line];
          exp_lines       = idle_lines;
          exp_lines[line] = rx.data[k];
          compare_lines("tx_lines", tx_lines, exp_lines);
        end
        repeat (bit_div) @(negedge clk);
        compare_lines("tx_lines", tx_lines, idle_lines);
        // the stop bit looks like idle on the lines, so the serializer must still be busy
        compare_flag("tx_busy", tx_busy, 1'b1);
        rx_q.push_back(rx);
      end
    end
  end

  initial
  begin : watchdog
    wait (table_ready);
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: the expected frames never arrived on the transmit lines");
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : stimulus
    stim_row_t row;
    int        exp_drops;
    arst_n     = 1'b0;
    wr_en      = 1'b0;
    wr_frame   = '0;
    bus_enable = '1;
    seed       = 32'he39dcacd;
    exp_drops  = 0;
    build_table();
    watchdog_cycles = 500;
    foreach (stim_table[i])
      watchdog_cycles += frame_cycles + int'(stim_table[i].idle);
    table_ready = 1'b1;

    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    compare_lines("tx_lines", tx_lines, idle_lines);
    compare_flag("tx_busy", tx_busy, 1'b0);
    compare_count("drop_count", drop_count, 16'h0000);

    foreach (stim_table[i])
    begin
      row = stim_table[i];
      repeat (row.idle)
      begin
        @(posedge clk);
        wr_en <= 1'b0;
      end
      @(negedge clk);
      // two idle cycles are enough for the previous decision to reach the counter
      if (row.idle >= 2)
        compare_count("drop_count", drop_count, 16'(exp_drops));
      @(posedge clk);
      wr_en      <= 1'b1;
      wr_frame   <= row.frame;
      bus_enable <= row.mask;
      if (row.accept)
        exp_q.push_back(row.frame);
      else
        exp_drops++;
    end
    @(posedge clk);
    wr_en <= 1'b0;

    while (rx_q.size() < exp_q.size())
      @(negedge clk);
    while (tx_busy)
      @(negedge clk);
    // a stray frame would start within this window
    repeat (frame_cycles) @(negedge clk);

    foreach (exp_q[i])
      compare_frame($sformatf("rx_frame[%0d]", i), rx_q[i], exp_q[i]);
    compare_count("drop_count", drop_count, 16'(exp_drops));

    if (rx_q.size() == exp_q.size())
    begin
      $display("Result: PASSED");
      $finish;
    end
    else
    begin
      $display("more frames arrived on the transmit lines than were accepted");
      $display("Result: FAILED");
      $fatal(1, "extra frames");
    end
  end

endmodule

`default_nettype wire

// ==== tb/bus_tx_hub_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_tx_hub_checker
  import bus_tx_pkg::*;
#(
  parameter logic IDLE_LEVEL = 1'b1
) (
  input  wire              clk,
  input  wire              arst_n,
  input  wire bus_lines_t  tx_lines,
  input  wire              tx_busy,
  input  wire              push,
  input  wire              full
);

  localparam bus_lines_t idle_lines = {num_buses{IDLE_LEVEL}};

  ////////////////////////////////////////////////////////////////////////////
  // transmit lines
  ////////////////////////////////////////////////////////////////////////////

  // the demux steers the serial bit to one line at most
  a_single_line: assert property (@(posedge clk) disable iff (!arst_n)
    $countones(tx_lines ^ idle_lines) <= 1)
  else $error("more than one transmit line left the idle level");

  // between frames the whole hub rests
  a_quiet_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
    !tx_busy |-> (tx_lines == idle_lines))
  else $error("a transmit line left the idle level while the serializer was idle");

  ////////////////////////////////////////////////////////////////////////////
  // fifo
  ////////////////////////////////////////////////////////////////////////////

  a_no_push_when_full: assert property (@(posedge clk) disable iff (!arst_n)
    push |-> !full)
  else $error("the request stage pushed into a full FIFO");

endmodule

`default_nettype wire

// ==== logic/bus_tx_hub.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_tx_hub
  import bus_tx_pkg::*;
#(
  parameter int   FIFO_DEPTH = 8,
  parameter int   BIT_DIV    = 4,
  parameter logic IDLE_LEVEL = 1'b1
) (
  input  wire              clk,
  input  wire              arst_n,
  input  wire              wr_en,
  input  wire tx_frame_t   wr_frame,
  input  wire bus_mask_t   bus_enable,
  output bus_lines_t       tx_lines,
  output logic             tx_busy,
  output logic [15:0]      drop_count
);

  ////////////////////////////////////////////////////////////////////////////
  // producer side
  ////////////////////////////////////////////////////////////////////////////

  logic      push;
  tx_frame_t push_frame;
  logic      full;

  tx_request_stage u_request (
    .clk        (clk),
    .arst_n     (arst_n),
    .wr_en      (wr_en),
    .wr_frame   (wr_frame),
    .bus_enable (bus_enable),
    .full       (full),
    .push       (push),
    .push_frame (push_frame),
    .drop_count (drop_count)
  );

  logic      pop;
  logic      empty;
  tx_frame_t head;

  frame_fifo #(
    .item_t (tx_frame_t),
    .DEPTH  (FIFO_DEPTH)
  ) u_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (push),
    .push_item (push_frame),
    .pop       (pop),
    .head      (head),
    .full      (full),
    .empty     (empty)
  );

  ////////////////////////////////////////////////////////////////////////////
  // consumer side
  ////////////////////////////////////////////////////////////////////////////

  bus_id_t sel;
  logic    ser_bit;

  bit_serializer #(
    .BIT_DIV (BIT_DIV)
  ) u_serializer (
    .clk     (clk),
    .arst_n  (arst_n),
    .empty   (empty),
    .head    (head),
    .pop     (pop),
    .sel     (sel),
    .ser_bit (ser_bit),
    .busy    (tx_busy)
  );

  bus_demux #(
    .IDLE_LEVEL (IDLE_LEVEL)
  ) u_demux (
    .sel     (sel),
    .ser_bit (ser_bit),
    .lines   (tx_lines)
  );

endmodule

`default_nettype wire

// ==== logic/bus_demux.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_demux
  import bus_tx_pkg::*;
#(
  parameter logic IDLE_LEVEL = 1'b1
) (
  input  wire bus_id_t  sel,
  input  wire           ser_bit,
  output bus_lines_t    lines
);

  localparam int line_idx_w = $clog2(num_buses);

  // every line rests at the idle level unless it is the one selected
  always_comb
  begin
    lines = {num_buses{IDLE_LEVEL}};
    // codes of 16 and up select nothing, so the whole hub stays quiet
    if (sel < bus_id_t'(num_buses))
      lines[sel[line_idx_w-1:0]] = ser_bit;
  end

endmodule

`default_nettype wire

// ==== logic/bit_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bit_serializer
  import bus_tx_pkg::*;
#(
  parameter int BIT_DIV = 4
) (
  input  wire              clk,
  input  wire              arst_n,
  input  wire              empty,
  input  wire tx_frame_t   head,
  output logic             pop,
  output bus_id_t          sel,
  output logic             ser_bit,
  output logic             busy
);

  // start, payload and stop
  localparam int frame_bits = payload_w + 2;
  localparam int div_w      = (BIT_DIV > 1) ? $clog2(BIT_DIV) : 1;

  typedef enum logic {
    st_idle,
    st_shift
  } state_t;

  state_t                 state;
  logic [div_w-1:0]       div_cnt;
  logic [4:0]             bit_idx;
  logic [frame_bits-1:0]  shreg;
  logic                   bit_end;
  logic                   frame_end;

  assign bit_end   = (div_cnt == div_w'(BIT_DIV - 1));
  assign frame_end = bit_end && (bit_idx == 5'(frame_bits - 1));

  // the idle cycle after a stop bit is the pop cycle, which keeps a gap on sel
  assign pop  = (state == st_idle) && !empty;
  assign busy = (state == st_shift);

  ////////////////////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state   <= st_idle;
      div_cnt <= '0;
      bit_idx <= '0;
      sel     <= bus_idle_sel;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          if (pop)
          begin
            state   <= st_shift;
            div_cnt <= '0;
            bit_idx <= '0;
            sel     <= head.bus;
          end
        end
        st_shift:
        begin
          if (frame_end)
          begin
            state <= st_idle;
            sel   <= bus_idle_sel;
          end
          else if (bit_end)
          begin
            div_cnt <= '0;
            bit_idx <= bit_idx + 5'd1;
          end
          else
            div_cnt <= div_cnt + 1'b1;
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // data path
  ////////////////////////////////////////////////////////////////////////////

  // start is dominant 0 and stop recessive 1, data goes out lsb first
  always_ff @(posedge clk)
  begin
    if (pop)
      shreg <= {1'b1, head.data, 1'b0};
    else if ((state == st_shift) && bit_end)
      shreg <= {1'b1, shreg[frame_bits-1:1]};
  end

  assign ser_bit = (state == st_shift) ? shreg[0] : 1'b1;

endmodule

`default_nettype wire

// ==== logic/frame_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_fifo #(
  parameter type item_t = logic [7:0],
  parameter int  DEPTH  = 8
) (
  input  wire    clk,
  input  wire    arst_n,
  input  wire    push,
  input  wire    [$bits(item_t)-1:0] push_item,
  input  wire    pop,
  output item_t  head,
  output logic   full,
  output logic   empty
);

  localparam int addr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  item_t             mem [DEPTH];
  logic [addr_w:0]   wr_ptr;
  logic [addr_w:0]   rd_ptr;
  logic [addr_w:0]   wr_ptr_nxt;
  logic [addr_w:0]   rd_ptr_nxt;
  logic              do_push;
  logic              do_pop;

  // requests against the wrong level are simply ignored
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_comb
  begin
    wr_ptr_nxt = wr_ptr;
    rd_ptr_nxt = rd_ptr;
    if (do_push)
      wr_ptr_nxt = wr_ptr + 1'b1;
    if (do_pop)
      rd_ptr_nxt = rd_ptr + 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // pointers and levels
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end
    else
    begin
      wr_ptr <= wr_ptr_nxt;
      rd_ptr <= rd_ptr_nxt;
      // same address with the wrap bit flipped means the writer is a lap ahead
      full   <= (wr_ptr_nxt[addr_w] != rd_ptr_nxt[addr_w]) &&
                (wr_ptr_nxt[addr_w-1:0] == rd_ptr_nxt[addr_w-1:0]);
      empty  <= (wr_ptr_nxt == rd_ptr_nxt);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr[addr_w-1:0]] <= item_t'(push_item);
  end

  // the oldest entry is always on view, pop only advances past it
  assign head = mem[rd_ptr[addr_w-1:0]];

endmodule

`default_nettype wire

// ==== logic/tx_request_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_request_stage
  import bus_tx_pkg::*;
(
  input  wire              clk,
  input  wire              arst_n,
  input  wire              wr_en,
  input  wire tx_frame_t   wr_frame,
  input  wire bus_mask_t   bus_enable,
  input  wire              full,
  output logic             push,
  output tx_frame_t        push_frame,
  output logic [15:0]      drop_count
);

  localparam int bus_idx_w = $clog2(num_buses);

  logic      wr_en_q;
  logic      target_ok_q;
  tx_frame_t frame_q;
  logic      target_ok;
  logic      drop;

  // the range check guards the mask lookup, so a code of 16 or more never indexes it
  always_comb
  begin
    target_ok = 1'b0;
    if (wr_frame.bus < bus_id_t'(num_buses))
      target_ok = bus_enable[wr_frame.bus[bus_idx_w-1:0]];
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_en_q     <= 1'b0;
      target_ok_q <= 1'b0;
    end
    else
    begin
      wr_en_q     <= wr_en;
      target_ok_q <= target_ok;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
      frame_q <= wr_frame;
  end

  // full here is the level seen while the registered strobe is present
  assign push       = wr_en_q && target_ok_q && !full;
  assign drop       = wr_en_q && !push;
  assign push_frame = frame_q;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      drop_count <= '0;
    else if (drop && (drop_count != 16'hffff))
      drop_count <= drop_count + 16'd1;
  end

endmodule

`default_nettype wire

// ==== logic/bus_tx_pkg.sv ====
`default_nettype none

package bus_tx_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus numbering
  ////////////////////////////////////////////////////////////////////////////

  localparam int num_buses = 16;

  // a 5-bit code like the hub select; 0 to 15 name a line, anything above is no line
  typedef logic [4:0] bus_id_t;

  // driven on the select while the serializer has nothing to send
  localparam bus_id_t bus_idle_sel = 5'd31;

  typedef logic [num_buses-1:0] bus_mask_t;
  typedef logic [num_buses-1:0] bus_lines_t;

  ////////////////////////////////////////////////////////////////////////////
  // frame
  ////////////////////////////////////////////////////////////////////////////

  localparam int payload_w = 16;

  typedef struct packed {
    bus_id_t               bus;
    logic [payload_w-1:0]  data;
  } tx_frame_t;

endpackage

`default_nettype wire
